//--- Makefile
VERILATOR  ?= verilator
TOP        := frame_checksum_tb
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := tests failed
PASS_MSG   := all tests passed
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG) || ! grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+hw
hw/stream_pkg.sv
hw/checksum_pkg.sv
hw/ebr_fifo.sv
hw/checksum_appender.sv
hw/frame_checksum_top.sv
dv/frame_checksum_checker.sv
dv/frame_checksum_tb.sv

//--- dv/frame_checksum_checker.sv
`default_nettype none

module frame_checksum_checker #(
    parameter integer DEPTH  = 16,
    parameter integer DATA_W = 8,
    parameter integer LVL_W  = 5
) (
    input wire logic              i_clock,
    input wire logic              i_reset,
    input wire logic [DATA_W-1:0] i_in_data,
    input wire logic              i_in_valid,
    input wire logic              o_in_ready,
    input wire logic [DATA_W-1:0] o_out_data,
    input wire logic              o_out_valid,
    input wire logic              i_out_ready,
    input wire logic [LVL_W-1:0]  water_level
);

timeunit 1ns;
timeprecision 1ps;

// sender must hold its beat until taken
in_hold: assert property (@(posedge i_clock) disable iff (i_reset)
    i_in_valid && !o_in_ready |=> i_in_valid && $stable(i_in_data))
    else $error("write side dropped or changed a beat before it was taken");

out_hold: assert property (@(posedge i_clock) disable iff (i_reset)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data))
    else $error("read side dropped or changed a beat before it was taken");

// init state follows every reset edge
reset_idle: assert property (@(posedge i_clock)
    i_reset |=> !o_out_valid && !o_in_ready)
    else $error("valid or ready high in the cycle after reset");

level_bound: assert property (@(posedge i_clock) disable iff (i_reset)
    water_level <= LVL_W'(DEPTH))
    else $error("water level above depth");

endmodule: frame_checksum_checker

bind ebr_fifo frame_checksum_checker #(
    .DEPTH  (DEPTH),
    .DATA_W ($bits(payload_t)),
    .LVL_W  (LVL_W)
) u_checker (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_in_data   (i_in_data),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out_data  (o_out_data),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .water_level (water_level)
);

`default_nettype wire

//--- dv/frame_checksum_tb.sv
`default_nettype none

`include "frame_macros.svh"

module frame_checksum_tb
    import stream_pkg::*;
    import checksum_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int RESET_CYCLES = 5;
localparam int STALL_CYCLES = 60;
localparam int DRAIN_IDLE   = 20;
localparam int PASSES       = 2;
localparam logic [31:0] SEED = 32'd75;
localparam int NUM_FRAMES   = 8;

// frames as length and first byte
localparam int FRAME_LEN [NUM_FRAMES] = '{1, 5, 40, 3, 12, 2, 17, 4};
localparam logic [`FRAME_DATA_W-1:0] FRAME_FIRST [NUM_FRAMES] =
    '{8'h10, 8'hfe, 8'h80, 8'h00, 8'hf0, 8'h7f, 8'h33, 8'hff};

logic                     i_clock;
logic                     i_reset;
logic [`FRAME_DATA_W-1:0] i_in_data;
logic                     i_in_last;
logic                     i_in_valid;
logic                     o_in_ready;
logic [`FRAME_DATA_W-1:0] o_out_data;
logic                     o_out_last;
logic                     o_out_check;
logic                     o_out_valid;
logic                     i_out_ready;

tx_beat_t    expected [$];  // scoreboard
logic [31:0] ready_rng;
logic [31:0] gap_rng;
logic        source_done;
logic        saw_in_stall;
int          mismatch_errors;
int          other_errors;
int          checks_done;
int          cycle_count;
int          timeout_limit;

frame_checksum_top DUT (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_in_data   (i_in_data),
    .i_in_last   (i_in_last),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out_data  (o_out_data),
    .o_out_last  (o_out_last),
    .o_out_check (o_out_check),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
);

always #5 i_clock = ~i_clock;

function automatic logic [31:0] step_xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic bit pick_ready();
    ready_rng = step_xorshift(ready_rng);
    return ready_rng[1:0] != 2'b00; // high three cycles in four
endfunction

function automatic bit pick_gap();
    gap_rng = step_xorshift(gap_rng);
    return gap_rng[1:0] == 2'b00;
endfunction

function automatic int timeout_cycles();
    int beats;
    int f;
    beats = 0;
    for (f = 0; f < NUM_FRAMES; f++) begin
        beats += FRAME_LEN[f] + 1;
    end
    return 4 * PASSES * beats + 200;
endfunction

task automatic apply_reset();
    i_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_clock);
    @(negedge i_clock);
    i_reset = 1'b0;
    assert (!o_in_ready && !o_out_valid) else begin
        other_errors++;
        $display("input ready or output valid high in the first cycle after reset");
    end
    @(negedge i_clock);
    assert (o_in_ready) else begin
        other_errors++;
        $display("input ready still low in the second cycle after reset");
    end
    repeat (3) begin
        assert (!o_out_valid) else begin
            other_errors++;
            $display("output valid high with no frame sent");
        end
        @(negedge i_clock);
    end
endtask

// expected beats of frame f per the checksum rule
task automatic queue_frame(input int f);
    csum_t    sum;
    tx_beat_t beat;
    int       i;
    sum = '0;
    for (i = 0; i < FRAME_LEN[f]; i++) begin
        beat.data = FRAME_FIRST[f] + 8'(i);
        beat.last = 1'b0;
        beat.is_check = 1'b0;
        expected.push_back(beat);
        sum = sum + beat.data;
    end
    beat.data = ~sum + 8'd1; // two's complement of the sum
    beat.last = 1'b1;
    beat.is_check = 1'b1;
    expected.push_back(beat);
endtask

task automatic send_byte(input logic [`FRAME_DATA_W-1:0] data, input logic last,
                         input bit with_gaps);
    while (with_gaps && pick_gap()) begin
        @(negedge i_clock);
    end
    i_in_data = data;
    i_in_last = last;
    i_in_valid = 1'b1;
    while (!o_in_ready) begin
        @(negedge i_clock);
    end
    @(negedge i_clock); // taken on the edge in between
    i_in_valid = 1'b0;
endtask

task automatic send_table(input bit with_gaps);
    int f;
    int i;
    for (f = 0; f < NUM_FRAMES; f++) begin
        queue_frame(f);
        for (i = 0; i < FRAME_LEN[f]; i++) begin
            send_byte(FRAME_FIRST[f] + 8'(i), i == FRAME_LEN[f] - 1, with_gaps);
        end
    end
    source_done = 1'b1;
endtask

task automatic sink_beats(input bit random_ready);
    tx_beat_t got;
    tx_beat_t exp;
    int       cycle;
    int       idle;
    cycle = 0;
    idle = 0;
    // runs until the source is done and the output stays quiet
    while (!(source_done && idle >= DRAIN_IDLE)) begin
        @(negedge i_clock);
        if (random_ready) begin
            i_out_ready = pick_ready();
        end else begin
            i_out_ready = (cycle >= STALL_CYCLES);
            if (!i_out_ready && !o_in_ready) begin
                saw_in_stall = 1'b1;
            end
        end
        cycle++;
        if (o_out_valid || !source_done) begin
            idle = 0;
        end else begin
            idle++;
        end
        // beat moves on the next rising edge
        if (o_out_valid && i_out_ready) begin
            got.data = o_out_data;
            got.last = o_out_last;
            got.is_check = o_out_check;
            assert (expected.size() > 0) else begin
                other_errors++;
                $display("output beat arrived with no expected beat queued");
            end
            if (expected.size() > 0) begin
                exp = expected.pop_front();
                checks_done++;
                assert (got == exp) else begin
                    mismatch_errors++;
                    $display("mismatch at %0t: expected data %02h last %0b check %0b, %s",
                             $time, exp.data, exp.last, exp.is_check, "got");
                    $display("    data %02h last %0b check %0b",
                             got.data, got.last, got.is_check);
                end
            end
        end
    end
    assert (expected.size() == 0) else begin
        other_errors++;
        $display("%0d expected beats never arrived", expected.size());
    end
    expected.delete();
endtask

task automatic print_counts();
    $display("errors %0d (mismatch %0d, other %0d), beats checked %0d",
             mismatch_errors + other_errors, mismatch_errors, other_errors, checks_done);
endtask

initial begin : watchdog
    timeout_limit = timeout_cycles();
    cycle_count = 0;
    while (cycle_count < timeout_limit) begin
        @(posedge i_clock);
        cycle_count++;
    end
    other_errors++;
    $display("timeout: run did not finish within %0d cycles", timeout_limit);
    print_counts();
    $display("tests failed");
    $finish;
end

initial begin : main
    i_clock = 1'b0;
    i_reset = 1'b1;
    i_in_data = '0;
    i_in_last = 1'b0;
    i_in_valid = 1'b0;
    i_out_ready = 1'b0;
    ready_rng = SEED;
    gap_rng = SEED;
    saw_in_stall = 1'b0;
    mismatch_errors = 0;
    other_errors = 0;
    checks_done = 0;
    apply_reset();

    // sink stalled first while the source runs back to back
    source_done = 1'b0;
    fork
        send_table(1'b0);
        sink_beats(1'b0);
    join
    assert (saw_in_stall) else begin
        other_errors++;
        $display("input ready never dropped while the output was stalled");
    end

    source_done = 1'b0;
    fork
        send_table(1'b1);
        sink_beats(1'b1);
    join

    i_out_ready = 1'b1;
    repeat (20) begin
        @(negedge i_clock);
        assert (!o_out_valid) else begin
            other_errors++;
            $display("extra output beat after all frames were received");
        end
    end

    print_counts();
    if (mismatch_errors + other_errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule: frame_checksum_tb

`default_nettype wire

//--- hw/checksum_appender.sv
`default_nettype none

module checksum_appender
    import stream_pkg::*;
    import checksum_pkg::*;
(
    input  wire logic     i_clock,
    input  wire logic     i_reset,
    input  wire rx_beat_t i_in_beat,
    input  wire logic     i_in_valid,
    output      logic     o_in_ready,
    output      tx_beat_t o_out_beat,
    output      logic     o_out_valid,
    input  wire logic     i_out_ready
);

appender_state_t state;
csum_t           sum;       // sum of the current frame so far
tx_beat_t        out_beat;
logic            out_valid;
logic            load;
logic            take;

// output register empty or draining this cycle
assign load = !out_valid || i_out_ready;

// no input while the check byte goes out
assign o_in_ready = (state == PASS) && load;
assign take = i_in_valid && o_in_ready;

always_ff @(posedge i_clock) begin
    if (i_reset == 1'b1) begin
        state <= PASS;
        sum <= '0;
        out_valid <= 1'b0;
    end else if (load) begin
        case (state)
        PASS: begin
            out_valid <= take;
            if (take) begin
                sum <= sum + i_in_beat.data;
                if (i_in_beat.last) begin
                    state <= CHECK;
                end
            end
        end
        CHECK: begin
            out_valid <= 1'b1;
            sum <= '0; // next frame starts fresh
            state <= PASS;
        end
        default: state <= PASS;
        endcase
    end
end

always_ff @(posedge i_clock) begin
    if (take) begin
        out_beat.data <= i_in_beat.data;
        out_beat.last <= 1'b0; // last moves to the check byte
        out_beat.is_check <= 1'b0;
    end else if (load && (state == CHECK)) begin
        // frame plus this byte sums to zero
        out_beat.data <= csum_t'(-sum);
        out_beat.last <= 1'b1;
        out_beat.is_check <= 1'b1;
    end
end

assign o_out_beat = out_beat;
assign o_out_valid = out_valid;

endmodule: checksum_appender

`default_nettype wire

//--- hw/checksum_pkg.sv
`default_nettype none

`include "frame_macros.svh"

package checksum_pkg;

// modulo-256 running sum
typedef logic [`FRAME_DATA_W-1:0] csum_t;

// PASS forwards frame bytes, CHECK emits the complement byte
typedef enum logic {
    PASS,
    CHECK
} appender_state_t;

endpackage: checksum_pkg

`default_nettype wire

//--- hw/ebr_fifo.sv
`default_nettype none

module ebr_fifo #(
    parameter type    payload_t = logic [7:0],
    parameter integer DEPTH     = 16
) (
    input  wire logic     i_clock,
    input  wire logic     i_reset,
    input  wire payload_t i_in_data,
    input  wire logic     i_in_valid,
    output      logic     o_in_ready,
    output      payload_t o_out_data,
    output      logic     o_out_valid,
    input  wire logic     i_out_ready
);

localparam integer PTR_W = $clog2(DEPTH);
localparam integer LVL_W = $clog2(DEPTH) + 1;

payload_t         buffer [0:DEPTH-1];
logic [PTR_W-1:0] head;
logic [PTR_W-1:0] tail;
logic [LVL_W-1:0] water_level; // beats currently held
logic             wr_fire;
logic             rd_fire;

enum logic [1:0] {
    ST_INIT,
    ST_EMPTY,
    ST_NORMAL,
    ST_FULL
} curr_state, next_state;

assign wr_fire = i_in_valid && o_in_ready;
assign rd_fire = o_out_valid && i_out_ready;

// head slot only, so a full buffer never overwrites the beat at tail
always_ff @(posedge i_clock) begin
    if (wr_fire) begin
        buffer[head] <= i_in_data;
    end
end

assign o_out_data = buffer[tail]; // unregistered read

always_ff @(posedge i_clock) begin
    if (i_reset == 1'b1) begin
        head <= '0;
        tail <= '0;
        water_level <= '0;
    end else begin
        if (wr_fire) begin
            head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
        end
        if (rd_fire) begin
            tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
        end
        case ({wr_fire, rd_fire})
        2'b10: water_level <= water_level + 1'b1;
        2'b01: water_level <= water_level - 1'b1;
        default: water_level <= water_level; // none or both
        endcase
    end
end

always_ff @(posedge i_clock) begin
    if (i_reset == 1'b1) begin
        curr_state <= ST_INIT;
    end else begin
        curr_state <= next_state;
    end
end

always_comb begin
    case (curr_state)
    ST_EMPTY: begin
        next_state = i_in_valid ? ST_NORMAL : ST_EMPTY;
        o_in_ready = 1'b1;
        o_out_valid = 1'b0;
    end
    ST_NORMAL: begin
        case ({i_in_valid, i_out_ready})
        2'b01: next_state = (water_level == LVL_W'(1)) ? ST_EMPTY : ST_NORMAL;
        2'b10: next_state = (water_level == LVL_W'(DEPTH - 1)) ? ST_FULL : ST_NORMAL;
        default: next_state = ST_NORMAL;
        endcase
        o_in_ready = 1'b1;
        o_out_valid = 1'b1;
    end
    ST_FULL: begin
        next_state = i_out_ready ? ST_NORMAL : ST_FULL; // only a read leaves full
        o_in_ready = 1'b0;
        o_out_valid = 1'b1;
    end
    default: begin
        // init lasts one cycle after reset
        next_state = ST_EMPTY;
        o_in_ready = 1'b0;
        o_out_valid = 1'b0;
    end
    endcase
end

endmodule: ebr_fifo

`default_nettype wire

//--- hw/frame_checksum_top.sv
`default_nettype none

`include "frame_macros.svh"

module frame_checksum_top
    import stream_pkg::*;
(
    input  wire logic                     i_clock,
    input  wire logic                     i_reset,
    input  wire logic [`FRAME_DATA_W-1:0] i_in_data,
    input  wire logic                     i_in_last,
    input  wire logic                     i_in_valid,
    output      logic                     o_in_ready,
    output      logic [`FRAME_DATA_W-1:0] o_out_data,
    output      logic                     o_out_last,
    output      logic                     o_out_check,
    output      logic                     o_out_valid,
    input  wire logic                     i_out_ready
);

rx_beat_t in_beat;
rx_beat_t fifo_rx_beat;     // input fifo to appender
logic     fifo_rx_valid;
logic     fifo_rx_ready;
tx_beat_t app_tx_beat;      // appender to output fifo
logic     app_tx_valid;
logic     app_tx_ready;
tx_beat_t out_beat;

assign in_beat.data = i_in_data;
assign in_beat.last = i_in_last;

ebr_fifo #(
    .payload_t (rx_beat_t),
    .DEPTH     (`IN_FIFO_DEPTH)
) u_in_fifo (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_in_data   (in_beat),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out_data  (fifo_rx_beat),
    .o_out_valid (fifo_rx_valid),
    .i_out_ready (fifo_rx_ready)
);

checksum_appender u_appender (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_in_beat   (fifo_rx_beat),
    .i_in_valid  (fifo_rx_valid),
    .o_in_ready  (fifo_rx_ready),
    .o_out_beat  (app_tx_beat),
    .o_out_valid (app_tx_valid),
    .i_out_ready (app_tx_ready)
);

ebr_fifo #(
    .payload_t (tx_beat_t),
    .DEPTH     (`OUT_FIFO_DEPTH)
) u_out_fifo (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_in_data   (app_tx_beat),
    .i_in_valid  (app_tx_valid),
    .o_in_ready  (app_tx_ready),
    .o_out_data  (out_beat),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
);

assign o_out_data = out_beat.data;
assign o_out_last = out_beat.last;
assign o_out_check = out_beat.is_check;

endmodule: frame_checksum_top

`default_nettype wire

//--- hw/frame_macros.svh
`ifndef FRAME_MACROS_SVH
`define FRAME_MACROS_SVH

// byte lane width on both stream sides
`define FRAME_DATA_W 8

// input side buffering
`define IN_FIFO_DEPTH 16

// output side buffering
`define OUT_FIFO_DEPTH 8

`endif

//--- hw/stream_pkg.sv
`default_nettype none

`include "frame_macros.svh"

package stream_pkg;

// beat from the source, before the checksum stage
typedef struct packed {
    logic [`FRAME_DATA_W-1:0] data;
    logic                     last; // end of frame
} rx_beat_t;

// beat toward the sink
typedef struct packed {
    logic [`FRAME_DATA_W-1:0] data;
    logic                     last;
    logic                     is_check; // appended checksum byte
} tx_beat_t;

endpackage: stream_pkg

`default_nettype wire
